// File: include/fpAdd_defines.svh
// Binary32 only; the working mantissa keeps 8 bits below the fraction for guard, round, sticky.
`ifndef FP_ADD_DEFINES_SVH
`define FP_ADD_DEFINES_SVH

////////////////////
// Binary32 fields
////////////////////
`define FP_EXP_W        8
`define FP_MAN_W        23
`define FP_WORD_W       32

////////////////////
// Working mantissa
////////////////////
`define WORK_W          32
`define WORK_HIDDEN     31            // Hidden bit position.
`define WORK_FRAC_LSB   8             // Fraction sits at 30..8.
`define WORK_GUARD      7
`define WORK_ROUND      6             // Sticky bits below this.

////////////////////
// Special encodings
////////////////////
`define EXP_MAX         255           // Infinity and NaN exponent.
`define INF_CLASH       32'h7FFF_FFFF // Infinity minus infinity.

`endif

// File: hdl/fpAddPkg.sv
// Vector types only; the widths come from the defines header, which must be on the include path.
`include "fpAdd_defines.svh"

package fpAddPkg;

    ////////////////////
    // Binary32 fields
    ////////////////////
    typedef logic [`FP_WORD_W-1:0] fpWord;     // Sign, exponent, fraction.
    typedef logic [`FP_EXP_W-1:0]  fpExp;      // Biased exponent.
    typedef logic [`FP_MAN_W-1:0]  fpMan;      // Stored fraction.

    ////////////////////
    // Datapath
    ////////////////////
    // Hidden bit, fraction, then guard, round and sticky.
    typedef logic [`WORK_W-1:0]    workMan;

    typedef logic [5:0]            shiftCount; // 0 to 32.

endpackage

// File: hdl/fpClassify.sv
// Stage 1 of 3; signalling NaNs are not quieted and B's sign is flipped on subtract.
`timescale 1ns/1ps
`include "fpAdd_defines.svh"

module fpClassify import fpAddPkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   inValid,
    input  fpWord  opA,
    input  fpWord  opB,
    input  logic   subtract,
    output logic   classValid,
    output fpWord  wordA,
    output fpWord  wordB,
    output logic   signA,
    output logic   signB,
    output fpExp   expA,
    output fpExp   expB,
    output workMan manA,
    output workMan manB,
    output logic   nanA,
    output logic   nanB,
    output logic   infA,
    output logic   infB,
    output logic   zeroA,
    output logic   zeroB,
    output logic   subA,
    output logic   subB
);

    fpWord flippedB;

    // Returns {nan, inf, zero, subnormal}.
    function automatic logic [3:0] classFlags(input fpWord word);
        fpExp exponent;
        fpMan fraction;
        exponent = word[`FP_WORD_W-2 -: `FP_EXP_W];
        fraction = word[`FP_MAN_W-1:0];
        classFlags[3] = (exponent == `FP_EXP_W'(`EXP_MAX)) && (fraction != '0);
        classFlags[2] = (exponent == `FP_EXP_W'(`EXP_MAX)) && (fraction == '0);
        classFlags[1] = (exponent == '0) && (fraction == '0);
        classFlags[0] = (exponent == '0) && (fraction != '0);
    endfunction

    function automatic fpExp workExp(input fpWord word);
        fpExp exponent;
        exponent = word[`FP_WORD_W-2 -: `FP_EXP_W];
        return (exponent == '0) ? fpExp'(1) : exponent;    // Subnormals scale as exponent 1.
    endfunction

    function automatic workMan workMantissa(input fpWord word);
        logic hidden;
        hidden = (word[`FP_WORD_W-2 -: `FP_EXP_W] != '0);
        return {hidden, word[`FP_MAN_W-1:0], {`WORK_FRAC_LSB{1'b0}}};
    endfunction

    assign flippedB = {opB[`FP_WORD_W-1] ^ subtract, opB[`FP_WORD_W-2:0]};

    always_ff @(posedge clock)
    begin
        if (reset)
            classValid <= 1'b0;
        else
            classValid <= inValid;
    end

    always_ff @(posedge clock)
    begin
        wordA <= opA;
        wordB <= flippedB;
        signA <= opA[`FP_WORD_W-1];
        signB <= flippedB[`FP_WORD_W-1];
        expA  <= workExp(opA);
        expB  <= workExp(flippedB);
        manA  <= workMantissa(opA);
        manB  <= workMantissa(flippedB);
        {nanA, infA, zeroA, subA} <= classFlags(opA);
        {nanB, infB, zeroB, subB} <= classFlags(flippedB);
    end

    // Downstream priority logic relies on exclusive classes.
    classOneHot: assert property (@(posedge clock) disable iff (reset)
        classValid |-> $onehot0({nanA, infA, zeroA, subA}) && $onehot0({nanB, infB, zeroB, subB}))
        else $error("operand carries more than one class flag");

endmodule

// File: hdl/fpAlign.sv
// Stage 2 of 3; the shift clamps at 32 and lost bits fold into the LSB and the sticky flag.
`timescale 1ns/1ps
`include "fpAdd_defines.svh"

module fpAlign import fpAddPkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   classValid,
    input  fpWord  wordA,
    input  fpWord  wordB,
    input  logic   signA,
    input  logic   signB,
    input  fpExp   expA,
    input  fpExp   expB,
    input  workMan manA,
    input  workMan manB,
    input  logic   nanA,
    input  logic   nanB,
    input  logic   infA,
    input  logic   infB,
    input  logic   zeroA,
    input  logic   zeroB,
    input  logic   subA,
    input  logic   subB,
    output logic   alignValid,
    output fpWord  alignWordA,
    output fpWord  alignWordB,
    output logic   alignSignA,
    output logic   alignSignB,
    output logic   alignNanA,
    output logic   alignNanB,
    output logic   alignInfA,
    output logic   alignInfB,
    output logic   alignZeroA,
    output logic   alignZeroB,
    output logic   alignSubA,
    output logic   alignSubB,
    output workMan alignedResult,
    output logic   carryOut,
    output logic   sticky,
    output logic   alignedSign,
    output fpExp   exponentOut
);

    logic                 swap;
    workMan               bigMan;
    workMan               smallMan;
    workMan               shiftedMan;
    fpExp                 bigExp;
    fpExp                 smallExp;
    fpExp                 expDiff;
    shiftCount            shiftAmt;
    logic [2*`WORK_W-1:0] shiftWide;
    logic                 lostBits;
    logic [`WORK_W:0]     sum;

    ////////////////////
    // Order and shift
    ////////////////////
    always_comb
    begin
        swap     = (expB > expA) || ((expB == expA) && (manB > manA));
        bigMan   = swap ? manB : manA;
        smallMan = swap ? manA : manB;
        bigExp   = swap ? expB : expA;
        smallExp = swap ? expA : expB;
        expDiff  = bigExp - smallExp;
        shiftAmt = (expDiff > `WORK_W) ? shiftCount'(`WORK_W) : shiftCount'(expDiff);

        // Low half catches everything shifted out.
        shiftWide  = {smallMan, {`WORK_W{1'b0}}} >> shiftAmt;
        lostBits   = |shiftWide[`WORK_W-1:0];
        shiftedMan = shiftWide[2*`WORK_W-1:`WORK_W] | workMan'(lostBits); // Jam into LSB.

        if (signA == signB)
            sum = {1'b0, bigMan} + {1'b0, shiftedMan};
        else
            sum = {1'b0, bigMan} - {1'b0, shiftedMan};  // Larger leads, no borrow.
    end

    ////////////////////
    // Stage register
    ////////////////////
    always_ff @(posedge clock)
    begin
        if (reset)
            alignValid <= 1'b0;
        else
            alignValid <= classValid;
    end

    always_ff @(posedge clock)
    begin
        alignWordA    <= wordA;
        alignWordB    <= wordB;
        alignSignA    <= signA;
        alignSignB    <= signB;
        alignNanA     <= nanA;
        alignNanB     <= nanB;
        alignInfA     <= infA;
        alignInfB     <= infB;
        alignZeroA    <= zeroA;
        alignZeroB    <= zeroB;
        alignSubA     <= subA;
        alignSubB     <= subB;
        alignedResult <= sum[`WORK_W-1:0];
        carryOut      <= sum[`WORK_W];
        sticky        <= lostBits;
        alignedSign   <= swap ? signB : signA;
        exponentOut   <= bigExp;
    end

    // The magnitude ordering must keep subtraction within range.
    noSubtractCarry: assert property (@(posedge clock) disable iff (reset)
        classValid && (signA != signB) |=> !carryOut)
        else $error("carry out of an effective subtraction");

endmodule

// File: hdl/fpNormalize.sv
// Stage 3 of 3; round to nearest even only, no exception flags, overflow saturates to infinity.
`timescale 1ns/1ps
`include "fpAdd_defines.svh"

module fpNormalize import fpAddPkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   alignValid,
    input  fpWord  alignWordA,
    input  fpWord  alignWordB,
    input  logic   alignSignA,
    input  logic   alignSignB,
    input  logic   alignNanA,
    input  logic   alignNanB,
    input  logic   alignInfA,
    input  logic   alignInfB,
    input  logic   alignZeroA,
    input  logic   alignZeroB,
    input  logic   alignSubA,
    input  logic   alignSubB,
    input  workMan alignedResult,
    input  logic   carryOut,
    input  logic   sticky,
    input  logic   alignedSign,
    input  fpExp   exponentOut,
    output logic   outValid,
    output fpWord  result
);

    localparam int EXP_EXT_W = `FP_EXP_W + 1;
    localparam int RND_W     = `WORK_W - `WORK_FRAC_LSB + 1;

    shiftCount              leadZeros;
    shiftCount              shiftAmt;
    workMan                 normMan;
    logic                   extraSticky;
    logic [EXP_EXT_W-1:0]   expBase;
    logic [EXP_EXT_W-1:0]   expFinal;
    logic                   guardBit;
    logic                   roundBit;
    logic                   stickyBit;
    logic                   roundUp;
    logic [RND_W-1:0]       rounded;
    fpMan                   fracFinal;
    fpWord                  normalWord;
    fpWord                  nextResult;

    function automatic shiftCount countZeros(input workMan value);
        shiftCount count;
        count = shiftCount'(`WORK_W);
        for (int i = 0; i < `WORK_W; i++)
            if (value[i])
                count = shiftCount'(`WORK_W - 1 - i);   // Highest set bit wins.
        return count;
    endfunction

    ////////////////////
    // Normal path
    ////////////////////
    always_comb
    begin
        leadZeros   = countZeros(alignedResult);
        extraSticky = 1'b0;
        if (carryOut)
        begin
            shiftAmt    = '0;
            expBase     = {1'b0, exponentOut} + EXP_EXT_W'(1);
            normMan     = {1'b1, alignedResult[`WORK_W-1:1]};
            extraSticky = alignedResult[0];
        end
        else if (leadZeros < exponentOut)
        begin
            shiftAmt = leadZeros;
            expBase  = {1'b0, exponentOut} - EXP_EXT_W'(leadZeros);
            normMan  = alignedResult << shiftAmt;
        end
        else
        begin
            // Exponent floor reached, result goes subnormal.
            shiftAmt = shiftCount'(exponentOut - 1'b1);
            expBase  = EXP_EXT_W'(1);
            normMan  = alignedResult << shiftAmt;
        end

        guardBit  = normMan[`WORK_GUARD];
        roundBit  = normMan[`WORK_ROUND];
        stickyBit = (|normMan[`WORK_ROUND-1:0]) | extraSticky | sticky;
        roundUp   = guardBit && (roundBit || stickyBit || normMan[`WORK_FRAC_LSB]);
        rounded   = {1'b0, normMan[`WORK_W-1:`WORK_FRAC_LSB]} + RND_W'(roundUp);

        if (rounded[RND_W-1])
        begin
            expFinal  = expBase + EXP_EXT_W'(1);          // Rounding carried past the hidden bit.
            fracFinal = '0;
        end
        else
        begin
            expFinal  = rounded[`FP_MAN_W] ? expBase : '0; // No hidden bit means subnormal.
            fracFinal = rounded[`FP_MAN_W-1:0];
        end

        if (expFinal >= `EXP_MAX)
            normalWord = {alignedSign, `FP_EXP_W'(`EXP_MAX), `FP_MAN_W'(0)};
        else
            normalWord = {alignedSign, expFinal[`FP_EXP_W-1:0], fracFinal};
    end

    ////////////////////
    // Special cases
    ////////////////////
    always_comb
    begin
        if (alignNanA)
            nextResult = alignWordA;
        else if (alignNanB)
            nextResult = alignWordB;
        else if (alignInfA && alignInfB && (alignSignA != alignSignB))
            nextResult = `INF_CLASH;
        else if (alignInfA)
            nextResult = alignWordA;
        else if (alignInfB)
            nextResult = alignWordB;
        else if (alignZeroA && !alignZeroB)
            nextResult = alignWordB;
        else if (alignZeroA || alignZeroB)
            nextResult = alignWordA;                      // Both zero keeps A.
        else if (alignSubA && alignSubB)
            nextResult = {alignedSign, fpExp'(alignedResult[`WORK_HIDDEN]),
                          alignedResult[`WORK_HIDDEN-1:`WORK_FRAC_LSB]};
        else
            nextResult = normalWord;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            outValid <= 1'b0;
        else
            outValid <= alignValid;
    end

    always_ff @(posedge clock)
    begin
        result <= nextResult;
    end

    // Above the exponent floor the zero count must bring the hidden bit to the top.
    hiddenBitSet: assert property (@(posedge clock) disable iff (reset)
        alignValid && !carryOut && (alignedResult != '0) && (leadZeros < exponentOut)
        |-> normMan[`WORK_HIDDEN])
        else $error("normalized mantissa lost its hidden bit");

endmodule

// File: hdl/fpAdder.sv
// Three-cycle binary32 add/subtract, one operation per cycle, no stall and no back-pressure.
`timescale 1ns/1ps
`include "fpAdd_defines.svh"

module fpAdder import fpAddPkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  inValid,
    input  fpWord opA,
    input  fpWord opB,
    input  logic  subtract,
    output logic  outValid,
    output fpWord result
);

    ////////////////////
    // Stage 1 to 2
    ////////////////////
    logic   classValid;
    fpWord  wordA;
    fpWord  wordB;
    logic   signA;
    logic   signB;
    fpExp   expA;
    fpExp   expB;
    workMan manA;
    workMan manB;
    logic   nanA, nanB;
    logic   infA, infB;
    logic   zeroA, zeroB;
    logic   subA, subB;

    ////////////////////
    // Stage 2 to 3
    ////////////////////
    logic   alignValid;
    fpWord  alignWordA;
    fpWord  alignWordB;
    logic   alignSignA, alignSignB;
    logic   alignNanA, alignNanB;
    logic   alignInfA, alignInfB;
    logic   alignZeroA, alignZeroB;
    logic   alignSubA, alignSubB;
    workMan alignedResult;
    logic   carryOut;
    logic   sticky;
    logic   alignedSign;
    fpExp   exponentOut;

    // Port names match across stages.
    fpClassify  i_classify  (.*);
    fpAlign     i_align     (.*);
    fpNormalize i_normalize (.*);

endmodule

// File: verif/fpAdderTb.sv
// Checks against an exact integer model; NaN in B keeps the subtract sign flip, a zero sum takes A's sign.
`timescale 1ns/1ps
`include "fpAdd_defines.svh"

module fpAdderTb import fpAddPkg::*; ();

    localparam int CLOCK_NS         = 4;
    localparam int DIRECTED_VECTORS = 32;
    localparam int STREAM_VECTORS   = 200;
    localparam int WATCHDOG_CYCLES  = (DIRECTED_VECTORS + STREAM_VECTORS) * 10 + 100;
    localparam int WIDE             = 320;   // Any binary32 magnitude in units of 2^-149.

    logic  clock = 1'b0;
    logic  reset;
    logic  inValid;
    fpWord opA;
    fpWord opB;
    logic  subtract;
    logic  outValid;
    fpWord result;
    int    valueErrors = 0;
    int    protocolErrors = 0;
    int    checkCount = 0;

    fpAdder i_dut (.*);

    always #(CLOCK_NS / 2) clock = ~clock;

    initial
    begin
        #(WATCHDOG_CYCLES * CLOCK_NS);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

    ////////////////////
    // Reference model
    ////////////////////
    function automatic logic isNan(input fpWord w);
        return (w[30:23] == 8'hFF) && (w[22:0] != '0);
    endfunction

    function automatic logic isInf(input fpWord w);
        return (w[30:23] == 8'hFF) && (w[22:0] == '0);
    endfunction

    function automatic logic [WIDE-1:0] magnitude(input fpWord w);
        if (w[30:23] == '0)
            return WIDE'(w[22:0]);
        return WIDE'({1'b1, w[22:0]}) << (w[30:23] - 1);
    endfunction

    function automatic fpWord modelAdd(input fpWord a, input fpWord b, input logic sub);
        fpWord           bEff;
        logic [WIDE-1:0] magA;
        logic [WIDE-1:0] magB;
        logic [WIDE-1:0] mag;
        logic [WIDE-1:0] keep;
        logic [WIDE-1:0] rest;
        logic [WIDE-1:0] half;
        logic            sign;
        int              top;
        int              shift;
        bEff = {b[31] ^ sub, b[30:0]};
        if (isNan(a))
            return a;
        if (isNan(bEff))
            return bEff;
        if (isInf(a) && isInf(bEff) && (a[31] != bEff[31]))
            return `INF_CLASH;
        if (isInf(a))
            return a;
        if (isInf(bEff))
            return bEff;
        if ((a[30:0] == '0) && (bEff[30:0] != '0))
            return bEff;
        if (bEff[30:0] == '0)
            return a;                                  // Covers both zero.
        magA = magnitude(a);
        magB = magnitude(bEff);
        if (a[31] == bEff[31])
            mag = magA + magB;
        else
            mag = (magA >= magB) ? magA - magB : magB - magA;
        sign = (magB > magA) ? bEff[31] : a[31];       // A leads on a tie.
        top = 0;
        for (int i = 0; i < WIDE; i++)
            if (mag[i])
                top = i;
        if (top < 24)
            return {sign, mag[30:0]};                  // Exact, no rounding needed.
        shift = top - 23;
        keep  = mag >> shift;
        rest  = mag & ((WIDE'(1) << shift) - WIDE'(1));
        half  = WIDE'(1) << (shift - 1);
        if ((rest > half) || ((rest == half) && keep[0]))
            keep = keep + WIDE'(1);
        if (keep[24])
        begin
            keep  = keep >> 1;
            shift = shift + 1;
        end
        if (shift + 1 >= `EXP_MAX)
            return {sign, 8'hFF, 23'h0};
        return {sign, 8'(shift + 1), keep[22:0]};
    endfunction

    ////////////////////
    // Check helpers
    ////////////////////
    task automatic checkWord(input string name, input fpWord got, input fpWord expected);
        checkCount++;
        assert (got === expected)
        else
        begin
            valueErrors++;
            $display("[ERROR] %0t ns: %s expected %08h, got %08h", $time, name, expected, got);
        end
    endtask

    task automatic checkOp(input fpWord a, input fpWord b, input logic sub);
        @(negedge clock);
        inValid  = 1'b1;
        opA      = a;
        opB      = b;
        subtract = sub;
        @(negedge clock);
        inValid = 1'b0;
        @(negedge clock);
        assert (!outValid)
        else
        begin
            protocolErrors++;
            $display("outValid came one cycle early at %0t ns", $time);
        end
        @(negedge clock);
        assert (outValid)
        else
        begin
            protocolErrors++;
            $display("outValid missing three cycles after inValid at %0t ns", $time);
        end
        checkWord("result", result, modelAdd(a, b, sub));
    endtask

    ////////////////////
    // Directed tests
    ////////////////////
    task automatic testExactSums();
        checkOp(32'h3F80_0000, 32'h4000_0000, 1'b0);   // 1.0 + 2.0.
        checkOp(32'h3FC0_0000, 32'h3E80_0000, 1'b0);   // 1.5 + 0.25.
        checkOp(32'hC120_0000, 32'hC0A0_0000, 1'b0);
    endtask

    task automatic testRounding();
        checkOp(32'h3F80_0000, 32'h3380_0000, 1'b0);   // Tie, even stays.
        checkOp(32'h3F80_0001, 32'h3380_0000, 1'b0);   // Tie, odd rounds up.
        checkOp(32'h3F80_0000, 32'h3380_0001, 1'b0);   // Just above half.
        checkOp(32'h3FFF_FFFF, 32'h3380_0000, 1'b0);   // Carry into exponent.
        checkOp(32'h7F7F_FFFF, 32'h7F7F_FFFF, 1'b0);   // Overflow.
        checkOp(32'h7F7F_FFFF, 32'h7300_0000, 1'b0);   // Rounds into overflow.
    endtask

    task automatic testSubtraction();
        checkOp(32'h3F80_0001, 32'h3F80_0000, 1'b1);   // Massive cancellation.
        checkOp(32'h3F80_0000, 32'h4000_0000, 1'b1);   // B leads the sign.
        checkOp(32'h0080_0001, 32'h0080_0000, 1'b1);
        checkOp(32'h00C0_0000, 32'h0080_0000, 1'b1);
        checkOp(32'h3F80_0000, 32'h3F80_0000, 1'b1);
        checkOp(32'hBF80_0000, 32'hBF80_0000, 1'b1);
    endtask

    task automatic testSpecials();
        checkOp(32'h7FC0_0001, 32'h7FC0_0002, 1'b0);
        checkOp(32'h3F80_0000, 32'h7FC0_0002, 1'b0);
        checkOp(32'h3F80_0000, 32'h7FC0_0002, 1'b1);
        checkOp(32'h7F80_0000, 32'h3F80_0000, 1'b0);
        checkOp(32'h3F80_0000, 32'hFF80_0000, 1'b0);
        checkOp(32'h7F80_0000, 32'h7F80_0000, 1'b1);
        checkOp(32'h7F80_0000, 32'hFF80_0000, 1'b0);
        checkOp(32'h0000_0000, 32'h3F80_0000, 1'b0);
        checkOp(32'h3F80_0000, 32'h8000_0000, 1'b0);
        checkOp(32'h8000_0000, 32'h0000_0000, 1'b0);
        checkOp(32'h0000_0000, 32'h3F80_0000, 1'b1);
    endtask

    task automatic testSubnormals();
        checkOp(32'h0000_0001, 32'h0000_0002, 1'b0);
        checkOp(32'h0040_0000, 32'h0040_0000, 1'b0);   // Reaches exponent 1.
        checkOp(32'h007F_FFFF, 32'h0000_0001, 1'b0);
        checkOp(32'h0000_0001, 32'h0080_0000, 1'b0);
        checkOp(32'h3F80_0000, 32'h0000_0001, 1'b0);
        checkOp(32'h0080_0000, 32'h0000_0001, 1'b1);
    endtask

    task automatic testStreaming();
        fpWord expectQ[$];
        int    issueQ[$];
        fpWord a;
        fpWord b;
        logic  sub;
        int    issued;
        int    received;
        int    cycle;
        int    issuedAt;
        issued   = 0;
        received = 0;
        cycle    = 0;
        while ((received < STREAM_VECTORS) && (cycle < STREAM_VECTORS + 10))
        begin
            @(negedge clock);
            if (outValid)
            begin
                assert (expectQ.size() != 0)
                else
                begin
                    protocolErrors++;
                    $display("outValid high with nothing in flight at %0t ns", $time);
                end
                if (expectQ.size() != 0)
                begin
                    issuedAt = issueQ.pop_front();
                    checkWord("result", result, expectQ.pop_front());
                    checkCount++;
                    assert (cycle - issuedAt == 3)
                    else
                    begin
                        protocolErrors++;
                        $display("Streamed result arrived with the wrong latency at %0t ns", $time);
                    end
                    received++;
                end
            end
            if (issued < STREAM_VECTORS)
            begin
                a   = $urandom();
                b   = $urandom();
                sub = 1'($urandom_range(1, 0));
                if ($urandom_range(1, 0) == 1)
                    b[30:23] = a[30:23] - 8'($urandom_range(3, 0)); // Near exponents.
                inValid  = 1'b1;
                opA      = a;
                opB      = b;
                subtract = sub;
                expectQ.push_back(modelAdd(a, b, sub));
                issueQ.push_back(cycle);
                issued++;
            end
            else
                inValid = 1'b0;
            cycle++;
        end
        assert (received == STREAM_VECTORS)
        else
        begin
            protocolErrors++;
            $display("Only %0d of %0d streamed results came back", received, STREAM_VECTORS);
        end
    endtask

    initial
    begin
        reset     = 1'b1;
        inValid   = 1'b0;
        opA       = '0;
        opB       = '0;
        subtract  = 1'b0;
        void'($urandom(16928));
        repeat (5) @(negedge clock);
        reset = 1'b0;
        testExactSums();
        testRounding();
        testSubtraction();
        testSpecials();
        testSubnormals();
        testStreaming();
        @(negedge clock);
        $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
                 checkCount, valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
hdl/fpAddPkg.sv
hdl/fpClassify.sv
hdl/fpAlign.sv
hdl/fpNormalize.sv
hdl/fpAdder.sv
verif/fpAdderTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = fpAdderTb
FILELIST = filelist.f
BUILDDIR = obj_dir
LOG      = sim.log
PASS_MSG = Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: build
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR) $(LOG)
